// File: common/taming_macros.svh
`ifndef TAMING_MACROS_SVH
`define TAMING_MACROS_SVH

// Memory map
// Zone table uses the top 4 bits
`define TAB_ZONE_BASE (taming_mem_pkg::mem_addr_t'(12'h100))
// Excitation errors use the top 10 bits
`define L_EXC_ERR_BASE (taming_mem_pkg::mem_addr_t'(12'h200))

// Zone table layout
`define TAB_ZONE_SIZE 153
`define L_SUBFR 40

// Taming decision
`define L_THRESH_ERR (taming_arith_pkg::word32_t'(983040000))

// Lag offsets around the pitch lag
`define T0_MARGIN_LO 50
`define T0_MARGIN_HI 8

`endif

// File: common/taming_arith_pkg.sv
`default_nettype none

package taming_arith_pkg;

	// Codec word types
	typedef logic signed [15:0] word16_t;
	typedef logic signed [31:0] word32_t;

	////////////////////////////////////////
	// Saturation limits
	////////////////////////////////////////

	localparam word16_t WORD16_MAX = 16'sh7fff;
	localparam word16_t WORD16_MIN = 16'sh8000;

	localparam word32_t WORD32_MAX = 32'sh7fff_ffff;
	localparam word32_t WORD32_MIN = 32'sh8000_0000;

endpackage

`default_nettype wire

// File: common/taming_mem_pkg.sv
`default_nettype none

package taming_mem_pkg;

	// Shared by the scratch and the constant memory
	typedef logic [11:0] mem_addr_t;

	// One data word of either memory
	typedef logic [31:0] mem_word_t;

	// Depth of the excitation-error scratch
	localparam int EXC_ERR_WORDS = 4;

	// Index width into the scratch
	localparam int EXC_ERR_IDX_W = $clog2(EXC_ERR_WORDS);

endpackage

`default_nettype wire

// File: common/arith_if.sv
`timescale 1ns/1ps
`default_nettype none

interface arith_if;
	import taming_arith_pkg::*;

	// 16-bit add
	word16_t add_a;
	word16_t add_b;
	word16_t add_sum;

	// 16-bit subtract
	word16_t sub_a;
	word16_t sub_b;
	word16_t sub_diff;

	// 32-bit subtract
	word32_t l_sub_a;
	word32_t l_sub_b;
	word32_t l_sub_diff;

	modport client (
		output add_a, add_b, sub_a, sub_b, l_sub_a, l_sub_b,
		input  add_sum, sub_diff, l_sub_diff
	);

	modport server (
		input  add_a, add_b, sub_a, sub_b, l_sub_a, l_sub_b,
		output add_sum, sub_diff, l_sub_diff
	);
endinterface

`default_nettype wire

// File: hw/arith_unit.sv
`timescale 1ns/1ps
`default_nettype none

module arith_unit (
	arith_if.server arith
);
	import taming_arith_pkg::*;

	word16_t sum_raw;
	word16_t diff_raw;
	word32_t l_diff_raw;
	logic sum_ovf;
	logic diff_ovf;
	logic l_diff_ovf;

	// Wrapping results first
	assign sum_raw = arith.add_a + arith.add_b;
	assign diff_raw = arith.sub_a - arith.sub_b;
	assign l_diff_raw = arith.l_sub_a - arith.l_sub_b;

	// Add overflows when equal signs give a different result sign
	assign sum_ovf = (arith.add_a[15] == arith.add_b[15]) &&
		(sum_raw[15] != arith.add_a[15]);

	// Subtract overflows when operand signs differ and result flips
	assign diff_ovf = (arith.sub_a[15] != arith.sub_b[15]) &&
		(diff_raw[15] != arith.sub_a[15]);
	assign l_diff_ovf = (arith.l_sub_a[31] != arith.l_sub_b[31]) &&
		(l_diff_raw[31] != arith.l_sub_a[31]);

	// Clamp toward the sign of the first operand
	assign arith.add_sum = sum_ovf ?
		(arith.add_a[15] ? WORD16_MIN : WORD16_MAX) : sum_raw;
	assign arith.sub_diff = diff_ovf ?
		(arith.sub_a[15] ? WORD16_MIN : WORD16_MAX) : diff_raw;
	assign arith.l_sub_diff = l_diff_ovf ?
		(arith.l_sub_a[31] ? WORD32_MIN : WORD32_MAX) : l_diff_raw;
endmodule

`default_nettype wire

// File: hw/zone_table_rom.sv
`timescale 1ns/1ps
`default_nettype none
`include "taming_macros.svh"

module zone_table_rom (
	input  logic clock,
	input  logic reset,
	input  taming_mem_pkg::mem_addr_t addr_i,
	output taming_mem_pkg::mem_word_t data_o
);
	import taming_mem_pkg::*;

	localparam int ZONE_MAX = 3;

	mem_word_t zone_tab [0:`TAB_ZONE_SIZE-1];
	logic [7:0] tab_idx;

	// Entry k holds k / L_SUBFR capped at the last zone
	for (genvar k = 0; k < `TAB_ZONE_SIZE; k++) begin : g_zone
		localparam int ZONE = k / `L_SUBFR;
		assign zone_tab[k] = mem_word_t'((ZONE > ZONE_MAX) ? ZONE_MAX : ZONE);
	end

	assign tab_idx = addr_i[7:0];

	always_ff @(posedge clock) begin
		if (reset) begin
			data_o <= '0;
		end else if (tab_idx < `TAB_ZONE_SIZE) begin
			data_o <= zone_tab[tab_idx];
		end else begin
			// Past the end reads as the last zone
			data_o <= mem_word_t'(ZONE_MAX);
		end
	end
endmodule

`default_nettype wire

// File: hw/exc_err_mem.sv
`timescale 1ns/1ps
`default_nettype none

module exc_err_mem (
	input  logic clock,
	input  logic reset,
	input  logic wr_en_i,
	input  logic [1:0] wr_addr_i,
	input  taming_mem_pkg::mem_word_t wr_data_i,
	input  taming_mem_pkg::mem_addr_t rd_addr_i,
	output taming_mem_pkg::mem_word_t rd_data_o
);
	import taming_mem_pkg::*;

	mem_word_t exc_err [0:EXC_ERR_WORDS-1];
	logic [EXC_ERR_IDX_W-1:0] rd_idx;

	// Only the low bits select a word
	assign rd_idx = rd_addr_i[EXC_ERR_IDX_W-1:0];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int k = 0; k < EXC_ERR_WORDS; k++) begin
				exc_err[k] <= '0;
			end
		end else if (wr_en_i) begin
			exc_err[wr_addr_i] <= wr_data_i;
		end
	end

	// Registered read with one clock of latency
	always_ff @(posedge clock) begin
		if (reset) begin
			rd_data_o <= '0;
		end else begin
			rd_data_o <= exc_err[rd_idx];
		end
	end
endmodule

`default_nettype wire

// File: test_err/test_err.sv
`timescale 1ns/1ps
`default_nettype none
`include "taming_macros.svh"

module test_err (
	input  logic clock,
	input  logic reset,
	input  logic start_i,
	input  taming_arith_pkg::word16_t T0_i,
	input  taming_arith_pkg::word16_t T0_frac_i,
	output logic done_o,
	output logic out_o,
	arith_if.client arith,
	output taming_mem_pkg::mem_addr_t const_addr_o,
	input  taming_mem_pkg::mem_word_t const_data_i,
	output taming_mem_pkg::mem_addr_t scratch_addr_o,
	input  taming_mem_pkg::mem_word_t scratch_data_i
);
	import taming_arith_pkg::*;
	import taming_mem_pkg::*;

	localparam mem_addr_t TAB_BASE = `TAB_ZONE_BASE;
	localparam mem_addr_t EXC_BASE = `L_EXC_ERR_BASE;

	typedef enum logic [3:0] {
		idle, round_lag, low_bound, read_zone1, read_zone2,
		start_scan, scan_check, scan_compare, finish
	} state_t;

	state_t state, state_next;
	logic done_next, out_next;
	logic frac_pos, frac_pos_next;
	word16_t t1, t1_next;
	word16_t i, i_next;
	word16_t zone1, zone1_next;
	word16_t zone2, zone2_next;
	word32_t L_maxloc, L_maxloc_next;

	// Strictly greater than zero
	function automatic logic is_pos32(input word32_t v);
		return !v[31] && (v != '0);
	endfunction

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= idle;
			done_o <= 1'b0;
			out_o <= 1'b0;
		end else begin
			state <= state_next;
			done_o <= done_next;
			out_o <= out_next;
		end
	end

	// Datapath registers
	always_ff @(posedge clock) begin
		frac_pos <= frac_pos_next;
		t1 <= t1_next;
		i <= i_next;
		zone1 <= zone1_next;
		zone2 <= zone2_next;
		L_maxloc <= L_maxloc_next;
	end

	////////////////////////////////////////
	// Next state and datapath control
	////////////////////////////////////////

	always_comb begin
		state_next = state;
		done_next = 1'b0;
		out_next = out_o;
		frac_pos_next = frac_pos;
		t1_next = t1;
		i_next = i;
		zone1_next = zone1;
		zone2_next = zone2;
		L_maxloc_next = L_maxloc;

		arith.add_a = '0;
		arith.add_b = '0;
		arith.sub_a = '0;
		arith.sub_b = '0;
		arith.l_sub_a = '0;
		arith.l_sub_b = '0;
		const_addr_o = '0;
		scratch_addr_o = '0;

		case (state)
			idle: begin
				// Capture the lag with the start pulse
				if (start_i) begin
					t1_next = T0_i;
					frac_pos_next = !T0_frac_i[15] && (T0_frac_i != '0);
					state_next = round_lag;
				end
			end
			round_lag: begin
				if (frac_pos) begin
					arith.add_a = t1;
					arith.add_b = 16'sd1;
					t1_next = arith.add_sum;
				end
				state_next = low_bound;
			end
			low_bound: begin
				arith.sub_a = t1;
				arith.sub_b = word16_t'(`T0_MARGIN_LO);
				// Floor the start index at zero
				i_next = arith.sub_diff[15] ? '0 : arith.sub_diff;
				state_next = read_zone1;
			end
			read_zone1: begin
				const_addr_o = {TAB_BASE[11:8], i[7:0]};
				state_next = read_zone2;
			end
			read_zone2: begin
				zone1_next = word16_t'(const_data_i[15:0]);
				arith.add_a = t1;
				arith.add_b = word16_t'(`T0_MARGIN_HI);
				const_addr_o = {TAB_BASE[11:8], arith.add_sum[7:0]};
				state_next = start_scan;
			end
			start_scan: begin
				// Scan runs downward from zone2
				zone2_next = word16_t'(const_data_i[15:0]);
				i_next = word16_t'(const_data_i[15:0]);
				L_maxloc_next = 32'sd1;
				state_next = scan_check;
			end
			scan_check: begin
				if (i < zone1) begin
					arith.l_sub_a = L_maxloc;
					arith.l_sub_b = `L_THRESH_ERR;
					out_next = is_pos32(arith.l_sub_diff);
					done_next = 1'b1;
					state_next = finish;
				end else begin
					scratch_addr_o = {EXC_BASE[11:2], i[1:0]};
					state_next = scan_compare;
				end
			end
			scan_compare: begin
				arith.l_sub_a = word32_t'(scratch_data_i);
				arith.l_sub_b = L_maxloc;
				if (is_pos32(arith.l_sub_diff)) begin
					L_maxloc_next = word32_t'(scratch_data_i);
				end
				arith.sub_a = i;
				arith.sub_b = 16'sd1;
				i_next = arith.sub_diff;
				state_next = scan_check;
			end
			finish: begin
				state_next = idle;
			end
			default: begin
				state_next = idle;
			end
		endcase
	end
endmodule

`default_nettype wire

// File: hw/taming_top.sv
`timescale 1ns/1ps
`default_nettype none

module taming_top (
	input  logic clock,
	input  logic reset,
	input  logic start_i,
	input  taming_arith_pkg::word16_t T0_i,
	input  taming_arith_pkg::word16_t T0_frac_i,
	input  logic exc_wr_en_i,
	input  logic [1:0] exc_wr_addr_i,
	input  taming_mem_pkg::mem_word_t exc_wr_data_i,
	output logic done_o,
	output logic out_o
);
	import taming_mem_pkg::*;

	mem_addr_t const_addr;
	mem_word_t const_data;
	mem_addr_t scratch_addr;
	mem_word_t scratch_data;

	// Shared arithmetic bus
	arith_if arith ();

	test_err test_err_i (
		.clock(clock),
		.reset(reset),
		.start_i(start_i),
		.T0_i(T0_i),
		.T0_frac_i(T0_frac_i),
		.done_o(done_o),
		.out_o(out_o),
		.arith(arith.client),
		.const_addr_o(const_addr),
		.const_data_i(const_data),
		.scratch_addr_o(scratch_addr),
		.scratch_data_i(scratch_data)
	);

	arith_unit arith_unit_i (
		.arith(arith.server)
	);

	zone_table_rom zone_table_rom_i (
		.clock(clock),
		.reset(reset),
		.addr_i(const_addr),
		.data_o(const_data)
	);

	// Loaded from outside between runs
	exc_err_mem exc_err_mem_i (
		.clock(clock),
		.reset(reset),
		.wr_en_i(exc_wr_en_i),
		.wr_addr_i(exc_wr_addr_i),
		.wr_data_i(exc_wr_data_i),
		.rd_addr_i(scratch_addr),
		.rd_data_o(scratch_data)
	);
endmodule

`default_nettype wire

// File: testbench/taming_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module taming_asserts (
	input logic clock,
	input logic reset,
	input logic start_i,
	input logic done_o,
	input logic out_o
);
	logic armed;
	logic reset_fail = 1'b0;
	logic pulse_fail = 1'b0;
	logic order_fail = 1'b0;
	logic any_fail;

	assign any_fail = reset_fail | pulse_fail | order_fail;

	// A start pulse was seen since the last done
	always_ff @(posedge clock) begin
		if (reset) begin
			armed <= 1'b0;
		end else if (done_o) begin
			armed <= 1'b0;
		end else if (start_i) begin
			armed <= 1'b1;
		end
	end

	////////////////////////////////////////
	// Output protocol
	////////////////////////////////////////

	assert property (@(posedge clock) reset |=> (!done_o && !out_o))
	else begin
		reset_fail = 1'b1;
		$error("done_o or out_o not cleared by reset");
	end

	assert property (@(posedge clock) disable iff (reset) done_o |=> !done_o)
	else begin
		pulse_fail = 1'b1;
		$error("done_o held for more than one cycle");
	end

	assert property (@(posedge clock) disable iff (reset) done_o |-> armed)
	else begin
		order_fail = 1'b1;
		$error("done_o without a preceding start_i");
	end
endmodule

`default_nettype wire

// File: testbench/taming_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "taming_macros.svh"

module taming_tb;
	import taming_arith_pkg::*;
	import taming_mem_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int NUM_CASES = 30;
	localparam int CASE_CYCLES = 40;
	localparam int RANDOM_CASES = 16;
	localparam longint LONG_MAX = 64'sd2147483647;
	localparam longint LONG_MIN = -64'sd2147483648;
	localparam word32_t HI_ERR = `L_THRESH_ERR + 32'sd1000;
	localparam word32_t LO_ERR = `L_THRESH_ERR - 32'sd1000;

	logic clock;
	logic reset;
	logic start_i;
	word16_t T0_i;
	word16_t T0_frac_i;
	logic exc_wr_en_i;
	logic [1:0] exc_wr_addr_i;
	mem_word_t exc_wr_data_i;
	logic done_o;
	logic out_o;

	// Copy of what was written into the scratch memory
	word32_t exc_model [0:3];
	int unsigned seed_ret;

	taming_top taming_top_i (
		.clock(clock),
		.reset(reset),
		.start_i(start_i),
		.T0_i(T0_i),
		.T0_frac_i(T0_frac_i),
		.exc_wr_en_i(exc_wr_en_i),
		.exc_wr_addr_i(exc_wr_addr_i),
		.exc_wr_data_i(exc_wr_data_i),
		.done_o(done_o),
		.out_o(out_o)
	);

	bind taming_top taming_asserts taming_asserts_i (
		.clock(clock),
		.reset(reset),
		.start_i(start_i),
		.done_o(done_o),
		.out_o(out_o)
	);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	function automatic int zone_of(input int k);
		int z;
		if (k >= `TAB_ZONE_SIZE) begin
			return 3;
		end
		z = k / `L_SUBFR;
		return (z > 3) ? 3 : z;
	endfunction

	function automatic longint clamp32(input longint v);
		if (v > LONG_MAX) begin
			return LONG_MAX;
		end
		if (v < LONG_MIN) begin
			return LONG_MIN;
		end
		return v;
	endfunction

	task automatic predict(input int t0, input int frac, output logic exp_out,
		output int exp_lat);
		int t1;
		int lo;
		int z1;
		int z2;
		int n;
		longint lmax;
		longint d;
		t1 = (frac > 0) ? t0 + 1 : t0;
		lo = t1 - `T0_MARGIN_LO;
		if (lo < 0) begin
			lo = 0;
		end
		z1 = zone_of(lo);
		z2 = zone_of(t1 + `T0_MARGIN_HI);
		n = z2 - z1 + 1;
		if (n < 0) begin
			n = 0;
		end
		exp_lat = 6 + 2 * n;
		lmax = 1;
		// Downward scan keeps the largest word
		for (int k = z2; k >= z1; k--) begin
			d = clamp32(longint'(exc_model[k % 4]) - lmax);
			if (d > 0) begin
				lmax = longint'(exc_model[k % 4]);
			end
		end
		exp_out = clamp32(lmax - longint'(`L_THRESH_ERR)) > 0;
	endtask

	// Mostly near the threshold and sometimes negative
	function automatic word32_t rand_err();
		if ($urandom % 8 == 0) begin
			return -word32_t'($urandom % 32'd16777216);
		end
		return `L_THRESH_ERR - 32'sd8388608 + word32_t'($urandom % 32'd16777216);
	endfunction

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////

	task automatic show_mismatch(input string name, input longint expected,
		input longint actual);
		$display("[FAIL] %s: expected %0d, actual %0d", name, expected, actual);
		$display("Simulation finished: FAIL");
	endtask

	task automatic write_exc(input int idx, input word32_t data);
		@(posedge clock);
		#2;
		exc_wr_en_i = 1'b1;
		exc_wr_addr_i = 2'(idx);
		exc_wr_data_i = mem_word_t'(data);
		@(posedge clock);
		#2;
		exc_wr_en_i = 1'b0;
		exc_model[idx] = data;
	endtask

	task automatic load_exc(input word32_t w0, input word32_t w1, input word32_t w2,
		input word32_t w3);
		write_exc(0, w0);
		write_exc(1, w1);
		write_exc(2, w2);
		write_exc(3, w3);
	endtask

	task automatic run_case(input string name, input int t0, input int frac,
		input bit pulse_mid);
		logic exp_out;
		int exp_lat;
		int lat;
		logic done_seen;
		predict(t0, frac, exp_out, exp_lat);
		@(posedge clock);
		#2;
		start_i = 1'b1;
		T0_i = word16_t'(t0);
		T0_frac_i = word16_t'(frac);
		@(posedge clock);
		#2;
		start_i = 1'b0;
		lat = 0;
		done_seen = 1'b0;
		while (!done_seen && lat < CASE_CYCLES) begin
			@(posedge clock);
			#1;
			lat++;
			done_seen = done_o;
			// A second start while busy is ignored
			if (pulse_mid && lat == 2) begin
				#1;
				start_i = 1'b1;
				T0_i = word16_t'(t0 + 30);
			end else if (pulse_mid && lat == 3) begin
				#1;
				start_i = 1'b0;
			end
		end
		if (!done_seen) begin
			$display("No done_o within %0d cycles in test %s", CASE_CYCLES, name);
			$display("Simulation finished: FAIL");
			$fatal(1, "done_o timeout");
		end
		assert (lat == exp_lat) else begin
			show_mismatch({name, " latency"}, exp_lat, lat);
			$fatal(1, "latency mismatch");
		end
		assert (out_o == exp_out) else begin
			show_mismatch({name, " out_o"}, exp_out, out_o);
			$fatal(1, "out_o mismatch");
		end
	endtask

	// Watchdog
	initial begin
		#(NUM_CASES * CASE_CYCLES * CLK_PERIOD);
		$display("Watchdog expired before all tests completed");
		$display("Simulation finished: FAIL");
		$fatal(1, "watchdog timeout");
	end

	// Bound checks raise a flag when they fail
	initial begin
		wait (taming_top_i.taming_asserts_i.any_fail);
		$display("A bound assertion failed");
		$display("Simulation finished: FAIL");
		$fatal(1, "bound assertion failure");
	end

	initial begin
		seed_ret = $urandom(32'h1e0f);
		reset = 1'b1;
		start_i = 1'b0;
		T0_i = '0;
		T0_frac_i = '0;
		exc_wr_en_i = 1'b0;
		exc_wr_addr_i = '0;
		exc_wr_data_i = '0;
		for (int k = 0; k < 4; k++) begin
			exc_model[k] = '0;
		end
		repeat (5) @(posedge clock);
		#2;
		reset = 1'b0;

		// Quiet outputs until the first start
		repeat (10) begin
			@(posedge clock);
			#1;
			assert (!done_o && !out_o) else begin
				show_mismatch("idle_after_reset", 0, {done_o, out_o});
				$fatal(1, "outputs not idle");
			end
		end

		// Lags around table boundaries
		load_exc(LO_ERR, LO_ERR, HI_ERR, LO_ERR);
		run_case("lag79_frac_pos", 79, 1, 1'b0);
		run_case("lag79_frac_zero", 79, 0, 1'b0);
		run_case("lag119_frac_pos", 119, 2, 1'b0);
		run_case("lag119_frac_neg", 119, -1, 1'b0);
		run_case("lag71_frac_pos", 71, 1, 1'b0);
		run_case("lag71_frac_zero", 71, 0, 1'b0);
		load_exc(HI_ERR, LO_ERR, LO_ERR, LO_ERR);
		run_case("lag89_frac_pos", 89, 1, 1'b0);
		run_case("lag89_frac_zero", 89, 0, 1'b0);

		// Start index clamps to zero
		run_case("low_lag20", 20, 0, 1'b0);
		run_case("low_lag30", 30, 1, 1'b0);
		run_case("low_lag45", 45, -1, 1'b0);

		// Long subtract saturation
		load_exc(WORD32_MIN, WORD32_MIN, WORD32_MIN, WORD32_MIN);
		run_case("all_min_words", 100, 0, 1'b0);
		write_exc(1, WORD32_MAX);
		run_case("max_word", 60, 0, 1'b0);

		run_case("start_during_run", 100, 1, 1'b1);

		for (int c = 0; c < RANDOM_CASES; c++) begin
			load_exc(rand_err(), rand_err(), rand_err(), rand_err());
			run_case($sformatf("random_%0d", c), 20 + int'($urandom % 124),
				int'($urandom % 4) - 1, 1'b0);
		end

		@(posedge clock);
		if (taming_top_i.taming_asserts_i.any_fail) begin
			$display("A bound assertion failed");
			$display("Simulation finished: FAIL");
			$fatal(1, "bound assertion failure");
		end else begin
			$display("Simulation finished: PASS");
			$finish;
		end
	end
endmodule

`default_nettype wire

// File: taming_top.f
+incdir+common
common/taming_arith_pkg.sv
common/taming_mem_pkg.sv
common/arith_if.sv
hw/arith_unit.sv
hw/zone_table_rom.sv
hw/exc_err_mem.sv
test_err/test_err.sv
hw/taming_top.sv
testbench/taming_asserts.sv
testbench/taming_tb.sv

// File: Makefile
TOP := taming_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f taming_top.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) +verilator+error+limit+100

lint:
	verilator --lint-only -Wall --timing --assert -f taming_top.f --top-module $(TOP)

clean:
	rm -rf obj_dir
